// ==== tb.f ====
src/arena_pkg.sv
src/vga_timing.sv
src/game_ctl.sv
src/draw_background.sv
src/obstacle_draw.sv
src/hit_detect.sv
src/arena_top.sv
bench/tb_arena.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_arena -f tb.f -Mdir obj_dir
	./obj_dir/Vtb_arena | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_arena.sv ====
module tb_arena
  import arena_pkg::*;
();

  localparam int H_ACTIVE    = 64;
  localparam int H_FRONT     = 4;
  localparam int H_SYNC      = 8;
  localparam int H_TOTAL     = 80;
  localparam int V_ACTIVE    = 48;
  localparam int V_FRONT     = 2;
  localparam int V_SYNC      = 3;
  localparam int V_TOTAL     = 56;
  localparam int LEFT_LINE   = 8;
  localparam int RIGHT_LINE  = 55;
  localparam int TOP_LINE    = 12;
  localparam int BOTTOM_LINE = 43;
  localparam int BORDER      = 1;
  localparam int OBST_W      = 4;
  localparam int HP_MAX      = 3;
  localparam int HP_STEP     = 4;

  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int IN_TOP       = TOP_LINE + BORDER;
  localparam int IN_BOTTOM    = BOTTOM_LINE - BORDER;
  localparam int X_FIRST      = LEFT_LINE + BORDER;
  localparam int X_LAST       = RIGHT_LINE - BORDER - OBST_W + 1;
  // about 70 frames over all tests, plus margin
  localparam int RUN_FRAMES   = 80;

  localparam int BTN_GAME    = 0;
  localparam int BTN_MENU    = 1;
  localparam int BTN_VICTORY = 2;

  logic               pclk;
  logic               rst_n;
  logic               game_button, menu_button, victory_button;
  logic [COORD_W-1:0] cursor_x, cursor_y;
  logic               hs, vs, blank;
  logic [COORD_W-1:0] hcount_out, vcount_out;
  rgb_t               rgb;

  // reference model of the frame being shown
  game_state_t m_state;
  int          m_hp;
  int          m_obst;

  logic [31:0] lfsr;
  int          errors;
  int          tests_passed;
  int          tests_failed;

  arena_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL),
    .LEFT_LINE(LEFT_LINE), .RIGHT_LINE(RIGHT_LINE), .TOP_LINE(TOP_LINE),
    .BOTTOM_LINE(BOTTOM_LINE), .BORDER(BORDER), .OBST_W(OBST_W),
    .HP_MAX(HP_MAX), .HP_STEP(HP_STEP)
  ) u_dut (
    .pclk(pclk), .rst_n(rst_n),
    .game_button(game_button), .menu_button(menu_button), .victory_button(victory_button),
    .cursor_x(cursor_x), .cursor_y(cursor_y),
    .hs(hs), .vs(vs), .blank(blank),
    .hcount_out(hcount_out), .vcount_out(vcount_out), .rgb(rgb)
  );

  always #2 pclk = ~pclk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic random_bits(input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic rgb_t expected_rgb(input int h, input int v);
    logic in_box;
    logic in_inner;
    in_box = h >= LEFT_LINE && h <= RIGHT_LINE && v >= TOP_LINE && v <= BOTTOM_LINE;
    in_inner = h >= X_FIRST && h <= RIGHT_LINE - BORDER && v >= IN_TOP && v <= IN_BOTTOM;
    case (m_state)
      ST_MENU: return COL_MENU;
      ST_OVER: return COL_OVER;
      ST_WIN:  return COL_WIN;
      default: ;
    endcase
    if (h >= m_obst && h < m_obst + OBST_W && v >= IN_TOP && v <= IN_BOTTOM) begin
      return COL_OBST;
    end
    if (in_box && !in_inner) begin
      return COL_BORDER;
    end
    if (v < TOP_LINE && h < m_hp * HP_STEP) begin
      return COL_HP;
    end
    return COL_PLAY;
  endfunction

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input int h, input int v);
    if (got !== exp) begin
      $display("Mismatch at %0t: pixel (%0d,%0d) is %h, expected %h", $time, h, v, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err_start);
    end
  endtask

  // returns on the falling edge where the output shows pixel (0,0) after a wrap
  task automatic wait_frame();
    int ph;
    int pv;
    ph = int'(hcount_out);
    pv = int'(vcount_out);
    @(negedge pclk);
    while (!(hcount_out == '0 && vcount_out == '0 && ph == H_TOTAL - 1 &&
             pv == V_TOTAL - 1)) begin
      ph = int'(hcount_out);
      pv = int'(vcount_out);
      @(negedge pclk);
    end
  endtask

  // game rules applied at the end of a frame
  task automatic step_model();
    int cx;
    int cy;
    cx = int'(cursor_x);
    cy = int'(cursor_y);
    if (m_state == ST_PLAY) begin
      if (cx >= m_obst && cx < m_obst + OBST_W && cy >= IN_TOP && cy <= IN_BOTTOM) begin
        m_hp--;
        if (m_hp == 0) begin
          m_state = ST_OVER;
        end
      end
      if (m_state == ST_PLAY) begin
        m_obst = (m_obst == X_LAST) ? X_FIRST : m_obst + 1;
      end else begin
        m_obst = X_FIRST;
      end
    end
  endtask

  task automatic check_frame();
    int   h;
    int   v;
    logic visible;
    for (v = 0; v < V_TOTAL; v++) begin
      for (h = 0; h < H_TOTAL; h++) begin
        visible = (h < H_ACTIVE) && (v < V_ACTIVE);
        check_count(int'(hcount_out), h, "column");
        check_count(int'(vcount_out), v, "row");
        check_bit(blank, !visible, "blank");
        if (visible) begin
          check_rgb(rgb, expected_rgb(h, v), h, v);
        end else begin
          // blanked pixels are black
          check_rgb(rgb, 12'h000, h, v);
        end
        @(negedge pclk);
      end
    end
    step_model();
  endtask

  task automatic pulse_button(input int which);
    case (which)
      BTN_GAME:    game_button = 1'b1;
      BTN_MENU:    menu_button = 1'b1;
      default:     victory_button = 1'b1;
    endcase
    @(negedge pclk);
    game_button    = 1'b0;
    menu_button    = 1'b0;
    victory_button = 1'b0;
  endtask

  task automatic test_reset();
    int err_start;
    err_start = errors;
    check_bit(hs, 1'b0, "hs after reset");
    check_bit(vs, 1'b0, "vs after reset");
    check_bit(blank, 1'b0, "blank after reset");
    wait_frame();
    check_frame();
    finish_test("reset and menu screen", err_start);
  endtask

  task automatic test_sync();
    int   err_start;
    int   cyc;
    int   last_hs;
    int   last_vs;
    int   n_vs;
    logic phs;
    logic pvs;
    err_start = errors;
    cyc = 0;
    last_hs = -1;
    last_vs = -1;
    n_vs = 0;
    phs = hs;
    pvs = vs;
    while (n_vs < 2 && cyc < 3 * FRAME_CYCLES) begin
      @(negedge pclk);
      cyc++;
      if (hs) begin
        check_bit(blank, 1'b1, "blank while hs high");
      end
      if (hs && !phs) begin
        if (last_hs >= 0) begin
          check_count(cyc - last_hs, H_TOTAL, "hs period");
        end
        last_hs = cyc;
      end
      if (vs && !pvs) begin
        if (last_vs >= 0) begin
          check_count(cyc - last_vs, FRAME_CYCLES, "vs period");
        end
        last_vs = cyc;
        n_vs++;
      end
      phs = hs;
      pvs = vs;
    end
    if (n_vs < 2) begin
      $display("vs did not rise twice within three frames");
      errors++;
    end
    finish_test("sync periods", err_start);
  endtask

  task automatic test_start();
    int err_start;
    err_start = errors;
    wait_frame();
    pulse_button(BTN_GAME);
    m_state = ST_PLAY;
    m_hp = HP_MAX;
    m_obst = X_FIRST;
    wait_frame();
    check_frame();
    finish_test("game start screen", err_start);
  endtask

  task automatic test_pillar();
    int err_start;
    int n;
    err_start = errors;
    // one full sweep, the last frame shows the pillar back at the left
    for (n = 0; n < X_LAST - X_FIRST + 1; n++) begin
      check_frame();
    end
    finish_test("pillar sweep and wrap", err_start);
  endtask

  task automatic test_hits();
    int err_start;
    int i;
    int x;
    int y;
    int sel;
    err_start = errors;
    for (i = 0; i < 3; i++) begin
      random_bits(6, x);
      random_bits(1, sel);
      if (sel != 0) begin
        random_bits(2, y);
        y = y + BOTTOM_LINE + 1;
      end else begin
        random_bits(3, y);
      end
      cursor_x = COORD_W'(x);
      cursor_y = COORD_W'(y);
      check_frame();
    end
    for (i = 0; i < HP_MAX; i++) begin
      random_bits(2, x);
      random_bits(4, y);
      cursor_x = COORD_W'(m_obst + x % OBST_W);
      cursor_y = COORD_W'(IN_TOP + y);
      check_frame();
    end
    // first pixel after the last hit is still drawn in play
    wait_frame();
    check_frame();
    finish_test("cursor hits and game over", err_start);
  endtask

  task automatic test_buttons();
    int err_start;
    err_start = errors;
    cursor_x = '0;
    cursor_y = '0;
    pulse_button(BTN_MENU);
    m_state = ST_MENU;
    wait_frame();
    check_frame();
    pulse_button(BTN_GAME);
    m_state = ST_PLAY;
    m_hp = HP_MAX;
    m_obst = X_FIRST;
    wait_frame();
    check_frame();
    pulse_button(BTN_VICTORY);
    m_state = ST_WIN;
    wait_frame();
    check_frame();
    pulse_button(BTN_MENU);
    m_state = ST_MENU;
    wait_frame();
    check_frame();
    finish_test("victory and menu buttons", err_start);
  endtask

  initial begin
    #(RUN_FRAMES * FRAME_CYCLES * 4);
    $display("Watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    pclk = 1'b0;
    rst_n = 1'b0;
    game_button = 1'b0;
    menu_button = 1'b0;
    victory_button = 1'b0;
    cursor_x = '0;
    cursor_y = '0;
    lfsr = 32'h4e1d_2b6c;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    m_state = ST_MENU;
    m_hp = HP_MAX;
    m_obst = X_FIRST;
    repeat (8) @(negedge pclk);
    rst_n = 1'b1;
    test_reset();
    test_sync();
    test_start();
    test_pillar();
    test_hits();
    test_buttons();
    $display("%0d tests ok, %0d tests failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== src/arena_top.sv ====
module arena_top
  import arena_pkg::*;
#(
  parameter int H_ACTIVE    = 1024,
  parameter int H_FRONT     = 24,
  parameter int H_SYNC      = 136,
  parameter int H_TOTAL     = 1344,
  parameter int V_ACTIVE    = 768,
  parameter int V_FRONT     = 3,
  parameter int V_SYNC      = 6,
  parameter int V_TOTAL     = 806,
  parameter int LEFT_LINE   = 361,
  parameter int RIGHT_LINE  = 661,
  parameter int TOP_LINE    = 317,
  parameter int BOTTOM_LINE = 617,
  parameter int BORDER      = 7,
  parameter int OBST_W      = 20,
  parameter int HP_MAX      = 3,
  parameter int HP_STEP     = 16
) (
  input  logic               pclk,
  input  logic               rst_n,
  input  logic               game_button,
  input  logic               menu_button,
  input  logic               victory_button,
  input  logic [COORD_W-1:0] cursor_x,
  input  logic [COORD_W-1:0] cursor_y,
  output logic               hs,
  output logic               vs,
  output logic               blank,
  output logic [COORD_W-1:0] hcount_out,
  output logic [COORD_W-1:0] vcount_out,
  output rgb_t               rgb
);

  localparam int HP_W = $clog2(HP_MAX + 1);

  logic [COORD_W-1:0] hcount_tim, vcount_tim, hcount_bg, vcount_bg;
  logic               hsync_tim, vsync_tim, hblnk_tim, vblnk_tim;
  logic               hsync_bg, vsync_bg, hblnk_bg, vblnk_bg;
  logic               hblnk_ob, vblnk_ob;
  logic               frame_end;
  logic               hit;
  logic [COORD_W-1:0] obst_x;
  logic [HP_W-1:0]    hp;
  game_state_t        state;
  rgb_t               rgb_bg;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
  ) u_timing (
    .pclk(pclk), .rst_n(rst_n),
    .hcount(hcount_tim), .vcount(vcount_tim),
    .hsync(hsync_tim), .vsync(vsync_tim),
    .hblnk(hblnk_tim), .vblnk(vblnk_tim),
    .frame_end(frame_end)
  );

  game_ctl #(.HP_MAX(HP_MAX)) u_game_ctl (
    .pclk(pclk), .rst_n(rst_n),
    .game_button(game_button), .menu_button(menu_button), .victory_button(victory_button),
    .hit(hit), .state(state), .hp(hp)
  );

  draw_background #(
    .LEFT_LINE(LEFT_LINE), .RIGHT_LINE(RIGHT_LINE), .TOP_LINE(TOP_LINE),
    .BOTTOM_LINE(BOTTOM_LINE), .BORDER(BORDER), .HP_MAX(HP_MAX), .HP_STEP(HP_STEP)
  ) u_background (
    .pclk(pclk), .rst_n(rst_n), .state(state), .hp(hp),
    .hcount_in(hcount_tim), .vcount_in(vcount_tim), .hsync_in(hsync_tim),
    .vsync_in(vsync_tim), .hblnk_in(hblnk_tim), .vblnk_in(vblnk_tim),
    .hcount_out(hcount_bg), .vcount_out(vcount_bg), .hsync_out(hsync_bg),
    .vsync_out(vsync_bg), .hblnk_out(hblnk_bg), .vblnk_out(vblnk_bg),
    .rgb_out(rgb_bg)
  );

  obstacle_draw #(
    .LEFT_LINE(LEFT_LINE), .RIGHT_LINE(RIGHT_LINE), .TOP_LINE(TOP_LINE),
    .BOTTOM_LINE(BOTTOM_LINE), .BORDER(BORDER), .OBST_W(OBST_W)
  ) u_obstacle (
    .pclk(pclk), .rst_n(rst_n), .state(state), .frame_end(frame_end),
    .hcount_in(hcount_bg), .vcount_in(vcount_bg), .hsync_in(hsync_bg),
    .vsync_in(vsync_bg), .hblnk_in(hblnk_bg), .vblnk_in(vblnk_bg), .rgb_in(rgb_bg),
    .hcount_out(hcount_out), .vcount_out(vcount_out), .hsync_out(hs),
    .vsync_out(vs), .hblnk_out(hblnk_ob), .vblnk_out(vblnk_ob),
    .rgb_out(rgb), .obst_x(obst_x)
  );

  hit_detect #(
    .TOP_LINE(TOP_LINE), .BOTTOM_LINE(BOTTOM_LINE), .BORDER(BORDER), .OBST_W(OBST_W)
  ) u_hit (
    .pclk(pclk), .rst_n(rst_n), .state(state), .frame_end(frame_end),
    .obst_x(obst_x), .cursor_x(cursor_x), .cursor_y(cursor_y), .hit(hit)
  );

  assign blank = hblnk_ob || vblnk_ob;

endmodule

// ==== src/hit_detect.sv ====
module hit_detect
  import arena_pkg::*;
#(
  parameter int TOP_LINE    = 317,
  parameter int BOTTOM_LINE = 617,
  parameter int BORDER      = 7,
  parameter int OBST_W      = 20
) (
  input  logic               pclk,
  input  logic               rst_n,
  input  game_state_t        state,
  input  logic               frame_end,
  input  logic [COORD_W-1:0] obst_x,
  input  logic [COORD_W-1:0] cursor_x,
  input  logic [COORD_W-1:0] cursor_y,
  output logic               hit
);

  localparam logic [COORD_W-1:0] IN_TOP    = COORD_W'(TOP_LINE + BORDER);
  localparam logic [COORD_W-1:0] IN_BOTTOM = COORD_W'(BOTTOM_LINE - BORDER);

  logic in_pillar;

  // obst_x still holds the column of the frame that is ending
  assign in_pillar = (cursor_x >= obst_x) && (cursor_x < obst_x + COORD_W'(OBST_W)) &&
                     (cursor_y >= IN_TOP) && (cursor_y <= IN_BOTTOM);

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= frame_end && (state == ST_PLAY) && in_pillar;
    end
  end

endmodule

// ==== src/obstacle_draw.sv ====
module obstacle_draw
  import arena_pkg::*;
#(
  parameter int LEFT_LINE   = 361,
  parameter int RIGHT_LINE  = 661,
  parameter int TOP_LINE    = 317,
  parameter int BOTTOM_LINE = 617,
  parameter int BORDER      = 7,
  parameter int OBST_W      = 20
) (
  input  logic               pclk,
  input  logic               rst_n,
  input  game_state_t        state,
  input  logic               frame_end,
  input  logic [COORD_W-1:0] hcount_in,
  input  logic [COORD_W-1:0] vcount_in,
  input  logic               hsync_in,
  input  logic               vsync_in,
  input  logic               hblnk_in,
  input  logic               vblnk_in,
  input  rgb_t               rgb_in,
  output logic [COORD_W-1:0] hcount_out,
  output logic [COORD_W-1:0] vcount_out,
  output logic               hsync_out,
  output logic               vsync_out,
  output logic               hblnk_out,
  output logic               vblnk_out,
  output rgb_t               rgb_out,
  output logic [COORD_W-1:0] obst_x
);

  localparam logic [COORD_W-1:0] X_FIRST   = COORD_W'(LEFT_LINE + BORDER);
  localparam logic [COORD_W-1:0] X_LAST    = COORD_W'(RIGHT_LINE - BORDER - OBST_W + 1);
  localparam logic [COORD_W-1:0] IN_TOP    = COORD_W'(TOP_LINE + BORDER);
  localparam logic [COORD_W-1:0] IN_BOTTOM = COORD_W'(BOTTOM_LINE - BORDER);

  // set once a whole frame has started in play
  logic moving;
  logic on_pillar;

  assign on_pillar = (state == ST_PLAY) &&
                     (hcount_in >= obst_x) && (hcount_in < obst_x + COORD_W'(OBST_W)) &&
                     (vcount_in >= IN_TOP) && (vcount_in <= IN_BOTTOM);

  // pillar steps one column per finished frame, first frame of play stays at X_FIRST
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      obst_x <= X_FIRST;
      moving <= 1'b0;
    end else if (state != ST_PLAY) begin
      obst_x <= X_FIRST;
      moving <= 1'b0;
    end else if (frame_end) begin
      moving <= 1'b1;
      if (moving) begin
        obst_x <= (obst_x == X_LAST) ? X_FIRST : obst_x + 1'b1;
      end
    end
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hcount_out <= '0;
      vcount_out <= '0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= on_pillar ? COL_OBST : rgb_in;
    end
  end

endmodule

// ==== src/draw_background.sv ====
module draw_background
  import arena_pkg::*;
#(
  parameter int LEFT_LINE   = 361,
  parameter int RIGHT_LINE  = 661,
  parameter int TOP_LINE    = 317,
  parameter int BOTTOM_LINE = 617,
  parameter int BORDER      = 7,
  parameter int HP_MAX      = 3,
  parameter int HP_STEP     = 16
) (
  input  logic                           pclk,
  input  logic                           rst_n,
  input  game_state_t                    state,
  input  logic [$clog2(HP_MAX + 1)-1:0]  hp,
  input  logic [COORD_W-1:0]             hcount_in,
  input  logic [COORD_W-1:0]             vcount_in,
  input  logic                           hsync_in,
  input  logic                           vsync_in,
  input  logic                           hblnk_in,
  input  logic                           vblnk_in,
  output logic [COORD_W-1:0]             hcount_out,
  output logic [COORD_W-1:0]             vcount_out,
  output logic                           hsync_out,
  output logic                           vsync_out,
  output logic                           hblnk_out,
  output logic                           vblnk_out,
  output rgb_t                           rgb_out
);

  localparam logic [COORD_W-1:0] IN_LEFT   = COORD_W'(LEFT_LINE + BORDER);
  localparam logic [COORD_W-1:0] IN_RIGHT  = COORD_W'(RIGHT_LINE - BORDER);
  localparam logic [COORD_W-1:0] IN_TOP    = COORD_W'(TOP_LINE + BORDER);
  localparam logic [COORD_W-1:0] IN_BOTTOM = COORD_W'(BOTTOM_LINE - BORDER);

  logic               in_box;
  logic               in_inner;
  logic [COORD_W-1:0] hp_len;
  rgb_t               rgb_nxt;

  assign in_box = (hcount_in >= COORD_W'(LEFT_LINE)) && (hcount_in <= COORD_W'(RIGHT_LINE)) &&
                  (vcount_in >= COORD_W'(TOP_LINE)) && (vcount_in <= COORD_W'(BOTTOM_LINE));
  assign in_inner = (hcount_in >= IN_LEFT) && (hcount_in <= IN_RIGHT) &&
                    (vcount_in >= IN_TOP) && (vcount_in <= IN_BOTTOM);
  // health bar length in pixels
  assign hp_len = COORD_W'(hp) * COORD_W'(HP_STEP);

  always_comb begin
    if (hblnk_in || vblnk_in) begin
      rgb_nxt = '0;
    end else begin
      case (state)
        ST_MENU: rgb_nxt = COL_MENU;
        ST_OVER: rgb_nxt = COL_OVER;
        ST_WIN:  rgb_nxt = COL_WIN;
        default: begin
          if (in_box && !in_inner) begin
            rgb_nxt = COL_BORDER;
          end else if ((vcount_in < COORD_W'(TOP_LINE)) && (hcount_in < hp_len)) begin
            rgb_nxt = COL_HP;
          end else begin
            rgb_nxt = COL_PLAY;
          end
        end
      endcase
    end
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hcount_out <= '0;
      vcount_out <= '0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

// ==== src/game_ctl.sv ====
module game_ctl
  import arena_pkg::*;
#(
  parameter int  HP_MAX = 3,
  localparam int HP_W   = $clog2(HP_MAX + 1)
) (
  input  logic            pclk,
  input  logic            rst_n,
  input  logic            game_button,
  input  logic            menu_button,
  input  logic            victory_button,
  input  logic            hit,
  output game_state_t     state,
  output logic [HP_W-1:0] hp
);

  game_state_t     state_nxt;
  logic [HP_W-1:0] hp_nxt;

  always_comb begin
    state_nxt = state;
    hp_nxt    = hp;
    // menu button wins from any state
    if (menu_button) begin
      state_nxt = ST_MENU;
    end else begin
      case (state)
        ST_MENU: begin
          if (game_button) begin
            state_nxt = ST_PLAY;
            hp_nxt    = HP_W'(HP_MAX);
          end
        end
        ST_PLAY: begin
          if (victory_button) begin
            state_nxt = ST_WIN;
          end else if (hit) begin
            hp_nxt = hp - 1'b1;
            // last point lost
            if (hp == HP_W'(1)) begin
              state_nxt = ST_OVER;
            end
          end
        end
        default: begin
          state_nxt = state;
        end
      endcase
    end
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_MENU;
      hp    <= HP_W'(HP_MAX);
    end else begin
      state <= state_nxt;
      hp    <= hp_nxt;
    end
  end

  a_hp_range: assert property (
    @(posedge pclk) disable iff (!rst_n) hp <= HP_W'(HP_MAX)
  );

  // hit_detect only tests while the frame ending was drawn in play
  a_hit_in_play: assert property (
    @(posedge pclk) disable iff (!rst_n) hit |-> $past(state) == ST_PLAY
  );

endmodule

// ==== src/vga_timing.sv ====
module vga_timing
  import arena_pkg::*;
#(
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int H_SYNC   = 136,
  parameter int H_TOTAL  = 1344,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3,
  parameter int V_SYNC   = 6,
  parameter int V_TOTAL  = 806
) (
  input  logic               pclk,
  input  logic               rst_n,
  output logic [COORD_W-1:0] hcount,
  output logic [COORD_W-1:0] vcount,
  output logic               hsync,
  output logic               vsync,
  output logic               hblnk,
  output logic               vblnk,
  output logic               frame_end
);

  localparam logic [COORD_W-1:0] H_LAST  = COORD_W'(H_TOTAL - 1);
  localparam logic [COORD_W-1:0] V_LAST  = COORD_W'(V_TOTAL - 1);
  localparam logic [COORD_W-1:0] HS_BEG  = COORD_W'(H_ACTIVE + H_FRONT);
  localparam logic [COORD_W-1:0] HS_END  = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam logic [COORD_W-1:0] VS_BEG  = COORD_W'(V_ACTIVE + V_FRONT);
  localparam logic [COORD_W-1:0] VS_END  = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC);

  logic [COORD_W-1:0] h_next;
  logic [COORD_W-1:0] v_next;

  always_comb begin
    h_next = hcount + 1'b1;
    v_next = vcount;
    if (hcount == H_LAST) begin
      h_next = '0;
      if (vcount == V_LAST) begin
        v_next = '0;
      end else begin
        v_next = vcount + 1'b1;
      end
    end
  end

  // flags are decoded from the next count so they stay aligned with the counters
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hcount    <= '0;
      vcount    <= '0;
      hsync     <= 1'b0;
      vsync     <= 1'b0;
      hblnk     <= 1'b0;
      vblnk     <= 1'b0;
      frame_end <= 1'b0;
    end else begin
      hcount    <= h_next;
      vcount    <= v_next;
      hsync     <= (h_next >= HS_BEG) && (h_next < HS_END);
      vsync     <= (v_next >= VS_BEG) && (v_next < VS_END);
      hblnk     <= h_next >= COORD_W'(H_ACTIVE);
      vblnk     <= v_next >= COORD_W'(V_ACTIVE);
      frame_end <= (h_next == H_LAST) && (v_next == V_LAST);
    end
  end

  a_hsync_in_blank: assert property (
    @(posedge pclk) disable iff (!rst_n) hsync |-> hblnk
  );

endmodule

// ==== src/arena_pkg.sv ====
package arena_pkg;

  // coordinate width shared by counters, cursor and pillar position
  localparam int COORD_W = 12;

  // 4 bits each of red, green and blue, red in the top nibble
  typedef logic [11:0] rgb_t;

  typedef enum logic [1:0] {
    ST_MENU,
    ST_PLAY,
    ST_OVER,
    ST_WIN
  } game_state_t;

  // screen colours per game state
  localparam rgb_t COL_MENU = 12'h00f;
  localparam rgb_t COL_PLAY = 12'h000;
  localparam rgb_t COL_OVER = 12'hf00;
  localparam rgb_t COL_WIN  = 12'h0f0;

  // arena elements
  localparam rgb_t COL_BORDER = 12'hfff;
  localparam rgb_t COL_HP     = 12'h0f0;
  localparam rgb_t COL_OBST   = 12'hff0;

endpackage
